/* rtl/instr_ctrl_pkg.sv */
package instr_ctrl_pkg;

    // instruction opcodes, word bits 62:60
    localparam logic [2:0] OP_CONFIG   = 3'd0;
    localparam logic [2:0] OP_LOAD_BLK = 3'd1;
    localparam logic [2:0] OP_EXEC_BLK = 3'd3;
    localparam logic [2:0] OP_STORE    = 3'd6;

    // kernel micro-command opcodes
    localparam logic [2:0] KOP_CONFIG = 3'd0;
    localparam logic [2:0] KOP_LOAD   = 3'd1;
    localparam logic [2:0] KOP_EXEC   = 3'd4;
    localparam logic [2:0] KOP_STORE  = 3'd3;

    // field and bus widths
    localparam int ADDR_W     = 40;
    localparam int OFFSET_W   = 32;
    localparam int BTT_W      = 16;
    localparam int DEPTH_W    = 9;
    localparam int ST_DEPTH_W = 8;
    localparam int TDEPTH_W   = 5;
    localparam int EXP_W      = 5;
    localparam int MAN_W      = 16;
    localparam int DM_CMD_W   = 88;
    localparam int PCCMD_W    = 32;
    localparam int FBK_W      = 8;

    // fixed fields of the data-mover command word
    localparam int DM_TYPE_BIT = 23;
    localparam int DM_EOF_BIT  = 30;
    localparam int DM_ADDR_LSB = 32;

    // feedback bits from the kernel
    localparam int FBK_STORE = 0;
    localparam int FBK_EXEC  = 1;
    localparam int FBK_LOADX = 2;
    localparam int FBK_LOADY = 3;

    // one 64-bit word, one view per instruction class
    // valid bit and opcode sit on top of every view
    typedef union packed {
        struct packed {
            logic                vld;
            logic [2:0]          op;
            logic                rsvd;
            logic                tile_sel;
            logic                y_sel;
            logic [DEPTH_W-1:0]  depth;
            logic [BTT_W-1:0]    btt;
            logic [OFFSET_W-1:0] addr_off;
        } ld;
        struct packed {
            logic               vld;
            logic [2:0]         op;
            logic               rsvd;
            logic               clr;
            logic               acc;
            logic [DEPTH_W-1:0] depth;
            logic [43:0]        rsvd_lo;
            logic               y_tile;
            logic               x_tile;
            logic [1:0]         mode;
        } ex;
        struct packed {
            logic                  vld;
            logic [2:0]            op;
            logic                  mt_en;
            logic [1:0]            mode;
            logic                  rsvd;
            logic [ST_DEPTH_W-1:0] depth;
            logic [BTT_W-1:0]      btt;
            logic [OFFSET_W-1:0]   addr_off;
        } st;
        struct packed {
            logic             vld;
            logic [2:0]       op;
            logic [38:0]      rsvd;
            logic [MAN_W-1:0] man;
            logic [EXP_W-1:0] exp;
        } cfg;
    } instr_w_u;

endpackage

/* rtl/unit_hazard_ctrl.sv */
`timescale 1ns/100ps

module unit_hazard_ctrl
    import instr_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_tvalid,
    input  instr_w_u         instr_tdata,
    input  logic             xi_slot_free,
    input  logic             yi_slot_free,
    input  logic             zo_slot_free,
    input  logic             pcfbk_tvalid,
    input  logic [FBK_W-1:0] pcfbk_tdata,
    output logic             instr_tready,
    output logic             accept,
    output logic             issue_xi,
    output logic             issue_yi,
    output logic             issue_zo
);

    logic is_load;
    logic is_exec;
    logic is_store;
    logic load_x;
    logic load_y;
    logic issue_ex;

    logic loadx_done;
    logic loady_done;
    logic exec_done;
    logic store_done;

    logic loadx_busy;
    logic loady_busy;
    logic exec_busy;
    logic store_busy;

    logic x_load_tile;
    logic y_load_tile;
    logic exec_x_tile;
    logic exec_y_tile;

    logic slot_stall;
    logic unit_stall;
    logic tile_stall;

    // class decode, words without the valid bit never stall
    assign is_load  = instr_tdata.ld.vld & (instr_tdata.ld.op == OP_LOAD_BLK);
    assign is_exec  = instr_tdata.ex.vld & (instr_tdata.ex.op == OP_EXEC_BLK);
    assign is_store = instr_tdata.st.vld & (instr_tdata.st.op == OP_STORE);
    assign load_x   = is_load & ~instr_tdata.ld.y_sel;
    assign load_y   = is_load & instr_tdata.ld.y_sel;

    // data-mover slot still holding an earlier command
    assign slot_stall = (load_x & ~xi_slot_free)
                      | (load_y & ~yi_slot_free)
                      | (is_store & ~zo_slot_free);

    // store waits for the execute that produces its result
    assign unit_stall = (is_exec & exec_busy)
                      | (is_store & (store_busy | exec_busy));

    // ping-pong tiles: never load the tile being executed and vice versa
    assign tile_stall = (is_exec & loadx_busy & (instr_tdata.ex.x_tile == x_load_tile))
                      | (is_exec & loady_busy & (instr_tdata.ex.y_tile == y_load_tile))
                      | (load_x & exec_busy & (instr_tdata.ld.tile_sel == exec_x_tile))
                      | (load_y & exec_busy & (instr_tdata.ld.tile_sel == exec_y_tile));

    assign instr_tready = ~(slot_stall | unit_stall | tile_stall);
    assign accept       = instr_tvalid & instr_tready;

    assign issue_xi = accept & load_x;
    assign issue_yi = accept & load_y;
    assign issue_zo = accept & is_store;
    assign issue_ex = accept & is_exec;

    // feedback is always taken, one done pulse per unit bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            loadx_done <= 1'b0;
            loady_done <= 1'b0;
            exec_done  <= 1'b0;
            store_done <= 1'b0;
        end else begin
            loadx_done <= pcfbk_tvalid & pcfbk_tdata[FBK_LOADX];
            loady_done <= pcfbk_tvalid & pcfbk_tdata[FBK_LOADY];
            exec_done  <= pcfbk_tvalid & pcfbk_tdata[FBK_EXEC];
            store_done <= pcfbk_tvalid & pcfbk_tdata[FBK_STORE];
        end
    end

    // unit busy flags, a new issue wins over a done pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            loadx_busy <= 1'b0;
            loady_busy <= 1'b0;
            exec_busy  <= 1'b0;
            store_busy <= 1'b0;
        end else begin
            if (issue_xi) begin
                loadx_busy <= 1'b1;
            end else if (loadx_done) begin
                loadx_busy <= 1'b0;
            end
            if (issue_yi) begin
                loady_busy <= 1'b1;
            end else if (loady_done) begin
                loady_busy <= 1'b0;
            end
            if (issue_ex) begin
                exec_busy <= 1'b1;
            end else if (exec_done) begin
                exec_busy <= 1'b0;
            end
            if (issue_zo) begin
                store_busy <= 1'b1;
            end else if (store_done) begin
                store_busy <= 1'b0;
            end
        end
    end

    // tiles in flight, only looked at while the unit is busy
    always_ff @(posedge clk) begin
        if (issue_xi) begin
            x_load_tile <= instr_tdata.ld.tile_sel;
        end
        if (issue_yi) begin
            y_load_tile <= instr_tdata.ld.tile_sel;
        end
        if (issue_ex) begin
            exec_x_tile <= instr_tdata.ex.x_tile;
            exec_y_tile <= instr_tdata.ex.y_tile;
        end
    end

    // kernel reports done only for an execute or store in flight
    a_busy_set_clr: assert property (@(posedge clk) disable iff (!rst_n)
        !(issue_ex && exec_done) && !(issue_zo && store_done))
        else $error("busy flag set and cleared on the same edge");

    a_issue_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({issue_xi, issue_yi, issue_zo}))
        else $error("more than one data-mover channel issued at once");

endmodule

/* rtl/dm_cmd_chan.sv */
`timescale 1ns/100ps

module dm_cmd_chan
    import instr_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue,
    input  logic [ADDR_W-1:0]   base_addr,
    input  logic [OFFSET_W-1:0] addr_offset,
    input  logic [BTT_W-1:0]    btt,
    input  logic                tready,
    output logic [DM_CMD_W-1:0] tdata,
    output logic                tvalid,
    output logic                slot_free
);

    logic [DM_CMD_W-1:0] cmd;

    // slot can take a new command once the current one goes out
    assign slot_free = ~tvalid | tready;

    // fixed-burst command word, everything not listed stays zero
    always_comb begin
        cmd                              = '0;
        cmd[BTT_W-1:0]                   = btt;
        cmd[DM_TYPE_BIT]                 = 1'b1;
        cmd[DM_EOF_BIT]                  = 1'b1;
        cmd[DM_ADDR_LSB +: ADDR_W]       = base_addr
                                         + {{(ADDR_W-OFFSET_W){1'b0}}, addr_offset};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tvalid <= 1'b0;
        end else if (issue) begin
            tvalid <= 1'b1;
        end else if (tready) begin
            tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tdata <= cmd;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tvalid && !tready |=> $stable(tdata) && tvalid)
        else $error("command changed while stalled by the data mover");

    // hazard control must have held the instruction back
    a_issue_free: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> slot_free)
        else $error("command issued into an occupied slot");

endmodule

/* rtl/kernel_cmd_gen.sv */
`timescale 1ns/100ps

module kernel_cmd_gen
    import instr_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               accept,
    input  instr_w_u           instr_tdata,
    output logic               pccmd_tvalid,
    output logic [PCCMD_W-1:0] pccmd_tdata
);

    instr_w_u              instr_q;
    logic                  cmd_vld;
    logic                  known_op;
    logic [ST_DEPTH_W-1:0] st_depth_p1;
    logic [TDEPTH_W-1:0]   st_tdepth;

    // unknown opcodes are swallowed like empty words
    assign known_op = instr_tdata.ld.op inside {OP_CONFIG, OP_LOAD_BLK, OP_EXEC_BLK, OP_STORE};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_vld <= 1'b0;
        end else begin
            cmd_vld <= accept & instr_tdata.ld.vld & known_op;
        end
    end

    // accepted word held for one cycle only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_q <= '0;
        end else if (accept) begin
            instr_q <= instr_tdata;
        end else begin
            instr_q <= '0;
        end
    end

    // transpose depth in groups of eight rows
    assign st_depth_p1 = {1'b0, instr_q.st.depth[ST_DEPTH_W-2:0]} + 1'b1;
    assign st_tdepth   = st_depth_p1[ST_DEPTH_W-1:3] - 1'b1;

    // micro-command with the opcode in bits 2:0
    always_comb begin
        pccmd_tdata = '0;
        if (instr_q.ld.vld) begin
            case (instr_q.ld.op)
                OP_CONFIG: begin
                    // scale factor form without constant select
                    pccmd_tdata = PCCMD_W'({instr_q.cfg.man,
                                            instr_q.cfg.exp,
                                            1'b1,
                                            3'b000,
                                            KOP_CONFIG});
                end
                OP_LOAD_BLK: begin
                    pccmd_tdata = PCCMD_W'({instr_q.ld.depth,
                                            1'b0,
                                            instr_q.ld.tile_sel,
                                            instr_q.ld.y_sel,
                                            KOP_LOAD});
                end
                OP_EXEC_BLK: begin
                    pccmd_tdata = PCCMD_W'({instr_q.ex.y_tile,
                                            instr_q.ex.x_tile,
                                            instr_q.ex.clr,
                                            instr_q.ex.acc,
                                            instr_q.ex.depth,
                                            1'b0,
                                            instr_q.ex.mode,
                                            KOP_EXEC});
                end
                OP_STORE: begin
                    pccmd_tdata = PCCMD_W'({instr_q.st.mt_en,
                                            st_tdepth,
                                            instr_q.st.depth,
                                            instr_q.st.mode,
                                            KOP_STORE});
                end
                default: begin
                    pccmd_tdata = '0;
                end
            endcase
        end
    end

    assign pccmd_tvalid = cmd_vld;

    // kernel sees a clean bus between commands
    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !pccmd_tvalid |-> pccmd_tdata == '0)
        else $error("kernel command data not zero while idle");

endmodule

/* rtl/core_instr_ctrl.sv */
`timescale 1ns/100ps

module core_instr_ctrl
    import instr_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // base addresses
    input  logic [ADDR_W-1:0]   xi_base_addr,
    input  logic [ADDR_W-1:0]   yizo_base_addr,
    // instruction stream
    input  logic                instr_tvalid,
    input  instr_w_u            instr_tdata,
    output logic                instr_tready,
    // data-mover command channels
    output logic [DM_CMD_W-1:0] mm2s_xi_tdata,
    output logic                mm2s_xi_tvalid,
    input  logic                mm2s_xi_tready,
    output logic [DM_CMD_W-1:0] mm2s_yi_tdata,
    output logic                mm2s_yi_tvalid,
    input  logic                mm2s_yi_tready,
    output logic [DM_CMD_W-1:0] s2mm_zo_tdata,
    output logic                s2mm_zo_tvalid,
    input  logic                s2mm_zo_tready,
    // kernel command and feedback
    output logic                pccmd_tvalid,
    output logic [PCCMD_W-1:0]  pccmd_tdata,
    input  logic                pcfbk_tvalid,
    input  logic [FBK_W-1:0]    pcfbk_tdata
);

    logic accept;
    logic issue_xi;
    logic issue_yi;
    logic issue_zo;
    logic xi_slot_free;
    logic yi_slot_free;
    logic zo_slot_free;

    unit_hazard_ctrl i_hazard (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_tvalid (instr_tvalid),
        .instr_tdata  (instr_tdata),
        .xi_slot_free (xi_slot_free),
        .yi_slot_free (yi_slot_free),
        .zo_slot_free (zo_slot_free),
        .pcfbk_tvalid (pcfbk_tvalid),
        .pcfbk_tdata  (pcfbk_tdata),
        .instr_tready (instr_tready),
        .accept       (accept),
        .issue_xi     (issue_xi),
        .issue_yi     (issue_yi),
        .issue_zo     (issue_zo)
    );

    kernel_cmd_gen i_kcmd (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .instr_tdata  (instr_tdata),
        .pccmd_tvalid (pccmd_tvalid),
        .pccmd_tdata  (pccmd_tdata)
    );

    // x operand loads
    dm_cmd_chan i_chan_xi (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue_xi),
        .base_addr   (xi_base_addr),
        .addr_offset (instr_tdata.ld.addr_off),
        .btt         (instr_tdata.ld.btt),
        .tready      (mm2s_xi_tready),
        .tdata       (mm2s_xi_tdata),
        .tvalid      (mm2s_xi_tvalid),
        .slot_free   (xi_slot_free)
    );

    // y operand loads
    dm_cmd_chan i_chan_yi (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue_yi),
        .base_addr   (yizo_base_addr),
        .addr_offset (instr_tdata.ld.addr_off),
        .btt         (instr_tdata.ld.btt),
        .tready      (mm2s_yi_tready),
        .tdata       (mm2s_yi_tdata),
        .tvalid      (mm2s_yi_tvalid),
        .slot_free   (yi_slot_free)
    );

    // result stores share the y base
    dm_cmd_chan i_chan_zo (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue_zo),
        .base_addr   (yizo_base_addr),
        .addr_offset (instr_tdata.st.addr_off),
        .btt         (instr_tdata.st.btt),
        .tready      (s2mm_zo_tready),
        .tdata       (s2mm_zo_tdata),
        .tvalid      (s2mm_zo_tvalid),
        .slot_free   (zo_slot_free)
    );

endmodule

/* bench/tb_core_instr_ctrl.sv */
`timescale 1ns/100ps

module tb_core_instr_ctrl
    import instr_ctrl_pkg::*;
();

    logic                clk;
    logic                rst_n;
    logic [ADDR_W-1:0]   xi_base_addr;
    logic [ADDR_W-1:0]   yizo_base_addr;
    logic                instr_tvalid;
    logic [63:0]         instr_word;
    logic                instr_tready;
    logic [2:0]          ch_tready;
    wire  [2:0]          ch_tvalid;
    wire  [DM_CMD_W-1:0] ch_tdata [3];
    logic                pccmd_tvalid;
    logic [PCCMD_W-1:0]  pccmd_tdata;
    logic                pcfbk_tvalid;
    logic [FBK_W-1:0]    pcfbk_tdata;

    // channel ready control, x is index 0, y 1, z 2
    logic                rand_ready;
    logic [2:0]          hold_mask;
    logic [2:0]          rdy_next;
    int                  cycle_cnt = 0;

    // reference state
    logic                acc;
    logic [63:0]         last_instr;
    logic                exp_kv;
    logic [2:0]          exp_v;
    logic [DM_CMD_W-1:0] exp_cmd [3];
    logic                lx_busy;
    logic                ly_busy;
    logic                ex_busy;
    logic                st_busy;
    logic                lx_tile;
    logic                ly_tile;

    core_instr_ctrl i_core_instr_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .xi_base_addr   (xi_base_addr),
        .yizo_base_addr (yizo_base_addr),
        .instr_tvalid   (instr_tvalid),
        .instr_tdata    (instr_word),
        .instr_tready   (instr_tready),
        .mm2s_xi_tdata  (ch_tdata[0]),
        .mm2s_xi_tvalid (ch_tvalid[0]),
        .mm2s_xi_tready (ch_tready[0]),
        .mm2s_yi_tdata  (ch_tdata[1]),
        .mm2s_yi_tvalid (ch_tvalid[1]),
        .mm2s_yi_tready (ch_tready[1]),
        .s2mm_zo_tdata  (ch_tdata[2]),
        .s2mm_zo_tvalid (ch_tvalid[2]),
        .s2mm_zo_tready (ch_tready[2]),
        .pccmd_tvalid   (pccmd_tvalid),
        .pccmd_tdata    (pccmd_tdata),
        .pcfbk_tvalid   (pcfbk_tvalid),
        .pcfbk_tdata    (pcfbk_tdata)
    );

    always #10 clk = ~clk;

    task automatic fail_check(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopping on first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == 3000) begin
            $display("timeout: the tests did not finish within 3000 clock cycles");
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // ready pattern decided at the edge, driven after it
    always @(posedge clk) begin
        rdy_next = rand_ready ? 3'($urandom) : 3'b111;
        rdy_next = rdy_next & ~hold_mask;
        #2;
        ch_tready = rdy_next;
    end

    function automatic logic [63:0] load_word(input logic y, input logic tile,
                                              input logic [8:0] depth,
                                              input logic [15:0] btt, input logic [31:0] off);
        logic [63:0] w;
        w = '0;
        w[63]    = 1'b1;
        w[62:60] = OP_LOAD_BLK;
        w[58]    = tile;
        w[57]    = y;
        w[56:48] = depth;
        w[47:32] = btt;
        w[31:0]  = off;
        return w;
    endfunction

    function automatic logic [63:0] exec_word(input logic [1:0] mode, input logic xt,
                                              input logic yt, input logic [8:0] depth,
                                              input logic accu, input logic clr);
        logic [63:0] w;
        w = '0;
        w[63]    = 1'b1;
        w[62:60] = OP_EXEC_BLK;
        w[58]    = clr;
        w[57]    = accu;
        w[56:48] = depth;
        w[3]     = yt;
        w[2]     = xt;
        w[1:0]   = mode;
        return w;
    endfunction

    function automatic logic [63:0] store_word(input logic mt, input logic [1:0] mode,
                                               input logic [7:0] depth,
                                               input logic [15:0] btt, input logic [31:0] off);
        logic [63:0] w;
        w = '0;
        w[63]    = 1'b1;
        w[62:60] = OP_STORE;
        w[59]    = mt;
        w[58:57] = mode;
        w[55:48] = depth;
        w[47:32] = btt;
        w[31:0]  = off;
        return w;
    endfunction

    function automatic logic [63:0] cfg_word(input logic [4:0] ex, input logic [15:0] man);
        logic [63:0] w;
        w = '0;
        w[63]    = 1'b1;
        w[62:60] = OP_CONFIG;
        w[20:5]  = man;
        w[4:0]   = ex;
        return w;
    endfunction

    function automatic logic known_op(input logic [2:0] op);
        return op == OP_CONFIG || op == OP_LOAD_BLK || op == OP_EXEC_BLK || op == OP_STORE;
    endfunction

    // data-mover channel an instruction goes to, 3 for none
    function automatic int target_chan(input logic [63:0] w);
        if (!w[63]) begin
            return 3;
        end
        if (w[62:60] == OP_LOAD_BLK) begin
            return w[57] ? 1 : 0;
        end
        return (w[62:60] == OP_STORE) ? 2 : 3;
    endfunction

    function automatic logic is_exec(input logic [63:0] w);
        return w[63] && w[62:60] == OP_EXEC_BLK;
    endfunction

    function automatic logic is_store(input logic [63:0] w);
        return w[63] && w[62:60] == OP_STORE;
    endfunction

    function automatic logic [DM_CMD_W-1:0] dm_word(input logic [ADDR_W-1:0] base,
                                                    input logic [63:0] w);
        logic [DM_CMD_W-1:0] d;
        d = '0;
        d[15:0]        = w[47:32];
        d[DM_TYPE_BIT] = 1'b1;
        d[DM_EOF_BIT]  = 1'b1;
        d[DM_ADDR_LSB +: ADDR_W] = base + {8'h00, w[31:0]};
        return d;
    endfunction

    function automatic logic [PCCMD_W-1:0] kcmd_word(input logic [63:0] w);
        logic [PCCMD_W-1:0] k;
        int                 td;
        k = '0;
        case (w[62:60])
            OP_LOAD_BLK: begin
                k[2:0]  = KOP_LOAD;
                k[3]    = w[57];
                k[4]    = w[58];
                k[14:6] = w[56:48];
            end
            OP_EXEC_BLK: begin
                k[2:0]  = KOP_EXEC;
                k[4:3]  = w[1:0];
                k[14:6] = w[56:48];
                k[15]   = w[57];
                k[16]   = w[58];
                k[17]   = w[2];
                k[18]   = w[3];
            end
            OP_STORE: begin
                // rows grouped by eight, depth taken modulo 128
                td       = ((int'(w[55:48]) % 128) + 1) / 8 - 1;
                k[2:0]   = KOP_STORE;
                k[4:3]   = w[58:57];
                k[12:5]  = w[55:48];
                k[17:13] = td[4:0];
                k[18]    = w[59];
            end
            OP_CONFIG: begin
                k[2:0]   = KOP_CONFIG;
                k[6]     = 1'b1;
                k[11:7]  = w[4:0];
                k[27:12] = w[20:5];
            end
            default: begin
                k = '0;
            end
        endcase
        return k;
    endfunction

    assign acc = instr_tvalid && instr_tready;

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_kv  <= 1'b0;
            exp_v   <= '0;
            lx_busy <= 1'b0;
            ly_busy <= 1'b0;
            ex_busy <= 1'b0;
            st_busy <= 1'b0;
        end else begin
            exp_kv <= acc && instr_word[63] && known_op(instr_word[62:60]);
            if (acc) begin
                last_instr <= instr_word;
            end
            for (int c = 0; c < 3; c++) begin
                if (acc && target_chan(instr_word) == c) begin
                    exp_v[c]   <= 1'b1;
                    exp_cmd[c] <= dm_word((c == 0) ? xi_base_addr : yizo_base_addr,
                                          instr_word);
                end else if (ch_tready[c]) begin
                    exp_v[c] <= 1'b0;
                end
            end
            // busy per unit until its feedback bit is seen
            if (acc && target_chan(instr_word) == 0) begin
                lx_busy <= 1'b1;
                lx_tile <= instr_word[58];
            end else if (pcfbk_tvalid && pcfbk_tdata[FBK_LOADX]) begin
                lx_busy <= 1'b0;
            end
            if (acc && target_chan(instr_word) == 1) begin
                ly_busy <= 1'b1;
                ly_tile <= instr_word[58];
            end else if (pcfbk_tvalid && pcfbk_tdata[FBK_LOADY]) begin
                ly_busy <= 1'b0;
            end
            if (acc && is_exec(instr_word)) begin
                ex_busy <= 1'b1;
            end else if (pcfbk_tvalid && pcfbk_tdata[FBK_EXEC]) begin
                ex_busy <= 1'b0;
            end
            if (acc && is_store(instr_word)) begin
                st_busy <= 1'b1;
            end else if (pcfbk_tvalid && pcfbk_tdata[FBK_STORE]) begin
                st_busy <= 1'b0;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> ch_tvalid == 3'b000 && !pccmd_tvalid && instr_tready)
        else fail_check("outputs not idle after reset");

    a_kcmd_valid: assert property (@(posedge clk) disable iff (!rst_n)
        pccmd_tvalid == exp_kv)
        else fail_check("kernel command valid does not follow acceptance");

    a_kcmd_data: assert property (@(posedge clk) disable iff (!rst_n)
        pccmd_tvalid |-> pccmd_tdata == kcmd_word(last_instr))
        else fail_check("wrong kernel micro-command");

    a_empty_accept: assert property (@(posedge clk) disable iff (!rst_n)
        instr_tvalid && !instr_word[63] |-> instr_tready)
        else fail_check("word without valid bit was stalled");

    a_exec_stall: assert property (@(posedge clk) disable iff (!rst_n)
        instr_tvalid && is_exec(instr_word) && ex_busy |-> !instr_tready)
        else fail_check("execute accepted while execute busy");

    a_store_stall: assert property (@(posedge clk) disable iff (!rst_n)
        instr_tvalid && is_store(instr_word) && (ex_busy || st_busy) |-> !instr_tready)
        else fail_check("store accepted while execute or store busy");

    a_tile_stall: assert property (@(posedge clk) disable iff (!rst_n)
        instr_tvalid && is_exec(instr_word)
        && ((lx_busy && instr_word[2] == lx_tile) || (ly_busy && instr_word[3] == ly_tile))
        |-> !instr_tready)
        else fail_check("execute accepted on a tile still loading");

    // stall lifted by the feedback pulse
    a_fbk_release: assert property (@(posedge clk) disable iff (!rst_n)
        pcfbk_tvalid && pcfbk_tdata[3:0] != 4'h0 && instr_tvalid && !instr_tready
        |-> ##[1:2] instr_tready)
        else fail_check("instruction not accepted within two cycles of feedback");

    for (genvar c = 0; c < 3; c++) begin : g_chan
        a_chan_valid: assert property (@(posedge clk) disable iff (!rst_n)
            ch_tvalid[c] == exp_v[c])
            else fail_check($sformatf("channel %0d valid mismatch", c));

        a_chan_data: assert property (@(posedge clk) disable iff (!rst_n)
            ch_tvalid[c] |-> ch_tdata[c] == exp_cmd[c])
            else fail_check($sformatf("channel %0d wrong command word", c));

        a_chan_hold: assert property (@(posedge clk) disable iff (!rst_n)
            ch_tvalid[c] && !ch_tready[c] |=> $stable(ch_tdata[c]))
            else fail_check($sformatf("channel %0d command changed under back-pressure", c));

        a_slot_stall: assert property (@(posedge clk) disable iff (!rst_n)
            instr_tvalid && target_chan(instr_word) == c && ch_tvalid[c] && !ch_tready[c]
            |-> !instr_tready)
            else fail_check($sformatf("channel %0d accepted into a held slot", c));
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic send_instr(input logic [63:0] w);
        instr_word   = w;
        instr_tvalid = 1'b1;
        @(negedge clk);
        while (!instr_tready) begin
            @(negedge clk);
        end
        step();
        instr_tvalid = 1'b0;
    endtask

    task automatic send_fbk(input logic [FBK_W-1:0] bits);
        pcfbk_tvalid = 1'b1;
        pcfbk_tdata  = bits;
        step();
        pcfbk_tvalid = 1'b0;
        pcfbk_tdata  = '0;
    endtask

    initial begin
        int i;
        void'($urandom(30));
        clk            = 1'b0;
        rst_n          = 1'b0;
        xi_base_addr   = 40'h12_3456_7000;
        yizo_base_addr = 40'h56_789a_b000;
        instr_tvalid   = 1'b0;
        instr_word     = '0;
        ch_tready      = 3'b111;
        pcfbk_tvalid   = 1'b0;
        pcfbk_tdata    = '0;
        rand_ready     = 1'b0;
        hold_mask      = 3'b000;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) step();

        // one load per operand buffer, then config
        send_instr(load_word(1'b0, 1'b0, 9'h1a5, 16'h0400, 32'hffff_f800));
        send_instr(load_word(1'b1, 1'b1, 9'h033, 16'h1200, 32'h0000_4000));
        send_fbk(8'h0c);
        send_instr(cfg_word(5'h13, 16'hbeef));

        // store behind a running execute
        send_instr(exec_word(2'd2, 1'b0, 1'b1, 9'h0ff, 1'b1, 1'b0));
        fork
            send_instr(store_word(1'b1, 2'd1, 8'hc7, 16'h0080, 32'h0001_0000));
            begin
                repeat (4) step();
                send_fbk(8'h01 << FBK_EXEC);
            end
        join
        send_fbk(8'h01 << FBK_STORE);

        // second execute waits for the first
        send_instr(exec_word(2'd1, 1'b0, 1'b0, 9'h010, 1'b0, 1'b1));
        fork
            send_instr(exec_word(2'd3, 1'b1, 1'b1, 9'h1f0, 1'b1, 1'b1));
            begin
                repeat (4) step();
                send_fbk(8'h01 << FBK_EXEC);
            end
        join
        send_fbk(8'h01 << FBK_EXEC);

        // execute on a tile with a load in flight
        send_instr(load_word(1'b0, 1'b1, 9'h044, 16'h0100, 32'h0000_0100));
        fork
            send_instr(exec_word(2'd0, 1'b1, 1'b0, 9'h044, 1'b0, 1'b0));
            begin
                repeat (4) step();
                send_fbk(8'h01 << FBK_LOADX);
            end
        join
        send_fbk(8'h01 << FBK_EXEC);

        // empty word and unknown opcode
        send_instr(load_word(1'b1, 1'b0, 9'h001, 16'h0010, 32'h0) & ~(64'h1 << 63));
        send_instr(64'ha000_0000_0000_1234);

        // x data mover held off
        hold_mask = 3'b001;
        send_instr(load_word(1'b0, 1'b0, 9'h080, 16'h0800, 32'h0020_0000));
        fork
            send_instr(load_word(1'b0, 1'b1, 9'h081, 16'h0810, 32'h0030_0000));
            begin
                repeat (6) step();
                hold_mask = 3'b000;
            end
        join
        send_fbk(8'h0c);

        // random traffic under random ready patterns
        rand_ready = 1'b1;
        for (i = 0; i < 24; i++) begin
            send_instr(load_word(1'($urandom), 1'($urandom), 9'($urandom),
                                 16'($urandom), $urandom));
        end
        for (i = 0; i < 12; i++) begin
            send_instr(store_word(1'($urandom), 2'($urandom), 8'($urandom),
                                  16'($urandom), $urandom));
            send_fbk(8'h01 << FBK_STORE);
        end
        for (i = 0; i < 4; i++) begin
            send_instr(cfg_word(5'($urandom), 16'($urandom)));
        end
        rand_ready = 1'b0;
        repeat (4) step();
        send_fbk(8'h0c);
        repeat (4) step();

        $display("TB PASSED");
        $finish;
    end

endmodule

/* flist.f */
rtl/instr_ctrl_pkg.sv
rtl/unit_hazard_ctrl.sv
rtl/dm_cmd_chan.sv
rtl/kernel_cmd_gen.sv
rtl/core_instr_ctrl.sv
bench/tb_core_instr_ctrl.sv
